//--- design/aos_pkg.sv
//--------------------------------------
// Soft-register fabric shared definitions
// Widths, address fields and vector types
//--------------------------------------

package aos_pkg;

	//--------------------------------------
	// Soft-register widths
	//--------------------------------------

	// Host address, byte granular
	localparam int SR_ADDR_W = 32;

	// One register word
	localparam int SR_DATA_W = 64;

	// Request payload as carried by the pipes
	// Write flag on top, then address, then data
	localparam int SR_REQ_W = 1 + SR_ADDR_W + SR_DATA_W;

	//--------------------------------------
	// Address fields
	//--------------------------------------

	// Application select starts here
	// Width follows log2 of the application count
	localparam int APP_SEL_LSB = 16;

	// Register index starts above the 8-byte word offset
	localparam int REG_SEL_LSB = 3;

	// Bits outside both fields alias onto the same register

	//--------------------------------------
	// Vector types
	//--------------------------------------

	// Soft-register address
	typedef logic [SR_ADDR_W-1:0] sr_addr_t;

	// Soft-register data word
	typedef logic [SR_DATA_W-1:0] sr_data_t;

	// Packed request payload
	typedef logic [SR_REQ_W-1:0] sr_req_t;

endpackage

//--- design/rst_pipe.sv
//--------------------------------------
// Reset re-timing chain
// Local active-low reset for one region
//--------------------------------------

`timescale 1ns/1ps

module rst_pipe #(
	parameter int STAGES = 3
) (
	input  logic clk,
	input  logic rst_n_in,
	output logic rst_n
);

	// One flop per stage, ones flow in after release
	logic [STAGES-1:0] chain_q;

	always_ff @(posedge clk) begin
		if (!rst_n_in) begin
			chain_q <= '0;
		end else begin
			chain_q[0] <= 1'b1;
			for (int i = 1; i < STAGES; i++) begin
				chain_q[i] <= chain_q[i-1];
			end
		end
	end

	// Release seen STAGES edges after the input rises
	assign rst_n = chain_q[STAGES-1];

endmodule

//--- design/softreg_pipe.sv
//--------------------------------------
// Soft-register strobe pipeline
// Fixed delay of STAGES cycles
//--------------------------------------

`timescale 1ns/1ps

module softreg_pipe #(
	parameter int STAGES = 2,
	parameter int WIDTH  = 64
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [WIDTH-1:0] in_payload,
	output logic             out_valid,
	output logic [WIDTH-1:0] out_payload
);

	// Stage registers, index 0 nearest the input
	logic [STAGES-1:0] valid_q;
	logic [WIDTH-1:0]  payload_q [STAGES];

	//--------------------------------------
	// Valid chain
	//--------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// Payload chain, qualified by valid downstream
	always_ff @(posedge clk) begin
		payload_q[0] <= in_payload;
		for (int i = 1; i < STAGES; i++) begin
			payload_q[i] <= payload_q[i-1];
		end
	end

	assign out_valid   = valid_q[STAGES-1];
	assign out_payload = payload_q[STAGES-1];

endmodule

//--- design/softreg_route_tree.sv
//--------------------------------------
// Soft-register route tree
// Steers host requests, merges responses
//--------------------------------------

`timescale 1ns/1ps

module softreg_route_tree #(
	parameter int NUM_APPS = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,

	// Host side
	input  logic                     host_req_valid,
	input  logic                     host_req_is_write,
	input  aos_pkg::sr_addr_t        host_req_addr,
	input  aos_pkg::sr_data_t        host_req_data,
	output logic                     host_resp_valid,
	output aos_pkg::sr_data_t        host_resp_data,

	// Application side
	output logic [NUM_APPS-1:0]      app_req_valid,
	output logic                     app_req_is_write,
	output aos_pkg::sr_addr_t        app_req_addr,
	output aos_pkg::sr_data_t        app_req_data,
	input  logic [NUM_APPS-1:0]      app_resp_valid,
	input  aos_pkg::sr_data_t        app_resp_data [NUM_APPS]
);

	// Select field width
	localparam int APP_SEL_W = $clog2(NUM_APPS);

	logic [APP_SEL_W-1:0] app_sel;
	logic [NUM_APPS-1:0]  app_hit;
	logic                 merged_valid;
	aos_pkg::sr_data_t    merged_data;

	//--------------------------------------
	// Request decode and steer
	//--------------------------------------

	// Target application from the address
	assign app_sel = host_req_addr[aos_pkg::APP_SEL_LSB +: APP_SEL_W];

	// One-hot hit vector for the current request
	always_comb begin
		for (int i = 0; i < NUM_APPS; i++) begin
			app_hit[i] = host_req_valid && (app_sel == APP_SEL_W'(i));
		end
	end

	// Registered steer, one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			app_req_valid <= '0;
		end else begin
			app_req_valid <= app_hit;
		end
	end

	// Payload broadcast to every application
	always_ff @(posedge clk) begin
		app_req_is_write <= host_req_is_write;
		app_req_addr     <= host_req_addr;
		app_req_data     <= host_req_data;
	end

	//--------------------------------------
	// Response merge
	//--------------------------------------

	// OR-reduce, idle applications contribute zero
	always_comb begin
		merged_valid = |app_resp_valid;
		merged_data  = '0;
		for (int i = 0; i < NUM_APPS; i++) begin
			if (app_resp_valid[i]) begin
				merged_data = merged_data | app_resp_data[i];
			end
		end
	end

	// Registered merge, one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_resp_valid <= 1'b0;
		end else begin
			host_resp_valid <= merged_valid;
		end
	end

	always_ff @(posedge clk) begin
		host_resp_data <= merged_data;
	end

	// Equal per-app latency keeps responses from colliding
	a_resp_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(app_resp_valid)
	) else $error("route tree: two application responses in one cycle");

endmodule

//--- design/app_regfile.sv
//--------------------------------------
// Application register block
// General registers plus a write counter
//--------------------------------------

`timescale 1ns/1ps

module app_regfile #(
	parameter int REGS_PER_APP = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  logic              req_is_write,
	input  aos_pkg::sr_addr_t req_addr,
	input  aos_pkg::sr_data_t req_data,
	output logic              resp_valid,
	output aos_pkg::sr_data_t resp_data
);

	localparam int IDX_W   = $clog2(REGS_PER_APP);
	// Top index holds the counter
	localparam int CNT_IDX = REGS_PER_APP - 1;

	logic [IDX_W-1:0]  reg_idx;
	logic              cnt_sel;
	logic              wr_en;
	aos_pkg::sr_data_t store_q [CNT_IDX];
	aos_pkg::sr_data_t wr_count_q;
	aos_pkg::sr_data_t rd_view [REGS_PER_APP];

	//--------------------------------------
	// Address decode
	//--------------------------------------
	assign reg_idx = req_addr[aos_pkg::REG_SEL_LSB +: IDX_W];
	assign cnt_sel = (reg_idx == IDX_W'(CNT_IDX));

	// Counter index is read only
	assign wr_en = req_valid && req_is_write && !cnt_sel;

	// Storage and counter, both read zero after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < CNT_IDX; i++) begin
				store_q[i] <= '0;
			end
			wr_count_q <= '0;
		end else if (wr_en) begin
			store_q[reg_idx] <= req_data;
			wr_count_q       <= wr_count_q + 1'b1;
		end
	end

	//--------------------------------------
	// Read path
	//--------------------------------------

	// Storage below, counter on top
	always_comb begin
		for (int i = 0; i < CNT_IDX; i++) begin
			rd_view[i] = store_q[i];
		end
		rd_view[CNT_IDX] = wr_count_q;
	end

	// One-cycle registered response, reads only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= req_valid && !req_is_write;
		end
	end

	always_ff @(posedge clk) begin
		resp_data <= rd_view[reg_idx];
	end

	// Read right behind a write to the same register sees the new data
	a_read_after_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en ##1 (req_valid && !req_is_write && reg_idx == $past(reg_idx))
		|=> resp_valid && resp_data == $past(req_data, 2)
	) else $error("regfile: read after write returned stale data");

endmodule

//--- design/aos_top.sv
//--------------------------------------
// Soft-register fabric top level
// Host pipes, route tree, app slices
//--------------------------------------

`timescale 1ns/1ps

module aos_top #(
	parameter int NUM_APPS     = 4,
	parameter int HOST_STAGES  = 2,
	parameter int APP_STAGES   = 2,
	parameter int REGS_PER_APP = 8,
	parameter int RST_STAGES   = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  logic              req_is_write,
	input  aos_pkg::sr_addr_t req_addr,
	input  aos_pkg::sr_data_t req_data,
	output logic              resp_valid,
	output aos_pkg::sr_data_t resp_data
);

	localparam int REQ_W  = aos_pkg::SR_REQ_W;
	localparam int DATA_W = aos_pkg::SR_DATA_W;
	localparam int ADDR_W = aos_pkg::SR_ADDR_W;

	//--------------------------------------
	// Reset pipes
	//--------------------------------------
	logic                fabric_rst_n;
	logic [NUM_APPS-1:0] app_rst_n;

	rst_pipe #(.STAGES(RST_STAGES)) u_fabric_rp (
		.clk      (clk),
		.rst_n_in (rst_n),
		.rst_n    (fabric_rst_n)
	);

	// Host request pipe
	logic              host_req_valid;
	aos_pkg::sr_req_t  host_req_payload;

	softreg_pipe #(.STAGES(HOST_STAGES), .WIDTH(REQ_W)) u_host_req_pipe (
		.clk         (clk),
		.rst_n       (fabric_rst_n),
		.in_valid    (req_valid),
		.in_payload  ({req_is_write, req_addr, req_data}),
		.out_valid   (host_req_valid),
		.out_payload (host_req_payload)
	);

	// Route tree, shared request payload out
	logic                host_resp_valid;
	aos_pkg::sr_data_t   host_resp_data;
	logic [NUM_APPS-1:0] app_req_valid;
	logic                app_req_is_write;
	aos_pkg::sr_addr_t   app_req_addr;
	aos_pkg::sr_data_t   app_req_data;
	logic [NUM_APPS-1:0] app_resp_valid;
	aos_pkg::sr_data_t   app_resp_data [NUM_APPS];

	softreg_route_tree #(.NUM_APPS(NUM_APPS)) u_route_tree (
		.clk               (clk),
		.rst_n             (fabric_rst_n),
		.host_req_valid    (host_req_valid),
		.host_req_is_write (host_req_payload[REQ_W-1]),
		.host_req_addr     (host_req_payload[DATA_W +: ADDR_W]),
		.host_req_data     (host_req_payload[DATA_W-1:0]),
		.host_resp_valid   (host_resp_valid),
		.host_resp_data    (host_resp_data),
		.app_req_valid     (app_req_valid),
		.app_req_is_write  (app_req_is_write),
		.app_req_addr      (app_req_addr),
		.app_req_data      (app_req_data),
		.app_resp_valid    (app_resp_valid),
		.app_resp_data     (app_resp_data)
	);

	// Host response pipe
	softreg_pipe #(.STAGES(HOST_STAGES), .WIDTH(DATA_W)) u_host_resp_pipe (
		.clk         (clk),
		.rst_n       (fabric_rst_n),
		.in_valid    (host_resp_valid),
		.in_payload  (host_resp_data),
		.out_valid   (resp_valid),
		.out_payload (resp_data)
	);

	//--------------------------------------
	// Application slices
	//--------------------------------------
	for (genvar a = 0; a < NUM_APPS; a++) begin : g_app
		logic              slice_req_valid;
		aos_pkg::sr_req_t  slice_req_payload;
		logic              slice_resp_valid;
		aos_pkg::sr_data_t slice_resp_data;

		// Local reset for this slice
		rst_pipe #(.STAGES(RST_STAGES)) u_app_rp (
			.clk      (clk),
			.rst_n_in (rst_n),
			.rst_n    (app_rst_n[a])
		);

		softreg_pipe #(.STAGES(APP_STAGES), .WIDTH(REQ_W)) u_req_pipe (
			.clk         (clk),
			.rst_n       (app_rst_n[a]),
			.in_valid    (app_req_valid[a]),
			.in_payload  ({app_req_is_write, app_req_addr, app_req_data}),
			.out_valid   (slice_req_valid),
			.out_payload (slice_req_payload)
		);

		app_regfile #(.REGS_PER_APP(REGS_PER_APP)) u_regfile (
			.clk          (clk),
			.rst_n        (app_rst_n[a]),
			.req_valid    (slice_req_valid),
			.req_is_write (slice_req_payload[REQ_W-1]),
			.req_addr     (slice_req_payload[DATA_W +: ADDR_W]),
			.req_data     (slice_req_payload[DATA_W-1:0]),
			.resp_valid   (slice_resp_valid),
			.resp_data    (slice_resp_data)
		);

		// Back toward the route tree
		softreg_pipe #(.STAGES(APP_STAGES), .WIDTH(DATA_W)) u_resp_pipe (
			.clk         (clk),
			.rst_n       (app_rst_n[a]),
			.in_valid    (slice_resp_valid),
			.in_payload  (slice_resp_data),
			.out_valid   (app_resp_valid[a]),
			.out_payload (app_resp_data[a])
		);
	end

endmodule

//--- dv/aos_tb.sv
//--------------------------------------
// Soft-register fabric testbench
// Model-checked reads through aos_top
//--------------------------------------

`timescale 1ns/1ps

module aos_tb;

	localparam int NUM_APPS     = 4;
	localparam int HOST_STAGES  = 2;
	localparam int APP_STAGES   = 2;
	localparam int REGS_PER_APP = 8;
	localparam int RST_STAGES   = 3;
	localparam int APP_W        = $clog2(NUM_APPS);
	localparam int IDX_W        = $clog2(REGS_PER_APP);
	localparam int CNT_IDX      = REGS_PER_APP - 1;
	localparam int TIMEOUT      = 1000;

	logic              clk;
	logic              rst_n;
	logic              req_valid;
	logic              req_is_write;
	aos_pkg::sr_addr_t req_addr;
	aos_pkg::sr_data_t req_data;
	logic              resp_valid;
	aos_pkg::sr_data_t resp_data;

	// Model state and bookkeeping
	aos_pkg::sr_data_t model_regs [NUM_APPS][REGS_PER_APP];
	aos_pkg::sr_data_t model_count [NUM_APPS];
	aos_pkg::sr_data_t expect_q [$];
	aos_pkg::sr_data_t exp_data;
	string             test_name;
	integer            seed;
	int                err_count;
	int                check_count;
	int                test_count;
	int                test_err_start;

	aos_top #(
		.NUM_APPS     (NUM_APPS),
		.HOST_STAGES  (HOST_STAGES),
		.APP_STAGES   (APP_STAGES),
		.REGS_PER_APP (REGS_PER_APP),
		.RST_STAGES   (RST_STAGES)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid    (req_valid),
		.req_is_write (req_is_write),
		.req_addr     (req_addr),
		.req_data     (req_data),
		.resp_valid   (resp_valid),
		.resp_data    (resp_data)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	//--------------------------------------
	// Reference model
	//--------------------------------------

	// Expected read value, only the two address fields count
	function automatic aos_pkg::sr_data_t expected_read(input aos_pkg::sr_addr_t addr);
		int app;
		int idx;
		app = addr[aos_pkg::APP_SEL_LSB +: APP_W];
		idx = addr[aos_pkg::REG_SEL_LSB +: IDX_W];
		if (idx == CNT_IDX)
			return model_count[app];
		return model_regs[app][idx];
	endfunction

	// Counter index writes are dropped and not counted
	task automatic model_write(input aos_pkg::sr_addr_t addr, input aos_pkg::sr_data_t data);
		int app;
		int idx;
		app = addr[aos_pkg::APP_SEL_LSB +: APP_W];
		idx = addr[aos_pkg::REG_SEL_LSB +: IDX_W];
		if (idx != CNT_IDX) begin
			model_regs[app][idx] = data;
			model_count[app]     = model_count[app] + 1;
		end
	endtask

	// Fields placed over arbitrary ignored bits
	function automatic aos_pkg::sr_addr_t make_addr(input int app, input int idx,
			input aos_pkg::sr_addr_t noise);
		aos_pkg::sr_addr_t addr;
		addr = noise;
		addr[aos_pkg::APP_SEL_LSB +: APP_W] = app[APP_W-1:0];
		addr[aos_pkg::REG_SEL_LSB +: IDX_W] = idx[IDX_W-1:0];
		return addr;
	endfunction

	function automatic aos_pkg::sr_data_t rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	//--------------------------------------
	// Stimulus helpers
	//--------------------------------------

	// One request per call, consecutive calls fill every cycle
	task automatic issue_req(input logic is_write, input aos_pkg::sr_addr_t addr,
			input aos_pkg::sr_data_t data);
		@(posedge clk);
		req_valid    <= 1'b1;
		req_is_write <= is_write;
		req_addr     <= addr;
		req_data     <= data;
		if (is_write)
			model_write(addr, data);
		else
			expect_q.push_back(expected_read(addr));
	endtask

	task automatic stop_on_stall(input string what);
		err_count++;
		$display("ERROR: %s in test %s, %0d reads never answered", what, test_name,
			expect_q.size());
		$display("Done: errors found");
		$finish;
	endtask

	// Go idle, wait until every read has come back
	task automatic drain();
		int waited;
		@(posedge clk);
		req_valid <= 1'b0;
		waited = 0;
		while (expect_q.size() != 0 && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic end_test();
		drain();
		if (expect_q.size() != 0)
			stop_on_stall("response stream stalled");
		else if (err_count == test_err_start)
			$display("test %s passed", test_name);
		else
			$display("test %s FAILED with %0d errors", test_name, err_count - test_err_start);
	endtask

	//--------------------------------------
	// Comparing process
	//--------------------------------------
	always @(negedge clk) begin
		if (resp_valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				err_count++;
				$display("ERROR: response in test %s with no read outstanding", test_name);
			end else begin
				exp_data = expect_q.pop_front();
				check_count++;
				if (resp_data !== exp_data) begin
					err_count++;
					$display("MISMATCH %s expected %h actual %h", test_name, exp_data, resp_data);
				end
			end
		end
	end

	//--------------------------------------
	// Test sequence
	//--------------------------------------
	initial begin
		int cycles;
		int app;
		int idx;
		int lat_exp;
		logic seen;
		aos_pkg::sr_data_t data;

		clk          = 1'b0;
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req_is_write = 1'b0;
		req_addr     = '0;
		req_data     = '0;
		seed         = 90;
		err_count    = 0;
		check_count  = 0;
		test_count   = 0;
		test_name    = "reset";
		for (int a = 0; a < NUM_APPS; a++) begin
			model_count[a] = '0;
			for (int r = 0; r < REGS_PER_APP; r++)
				model_regs[a][r] = '0;
		end

		// Reset, then let the reset pipes release
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (RST_STAGES) @(posedge clk);

		// Everything reads zero
		start_test("reset_zero");
		for (int a = 0; a < NUM_APPS; a++)
			for (int r = 0; r < REGS_PER_APP; r++)
				issue_req(1'b0, make_addr(a, r, '0), '0);
		end_test();

		// Fill one app at a time, read back the whole fabric
		start_test("write_read");
		for (int a = 0; a < NUM_APPS; a++) begin
			for (int r = 0; r < CNT_IDX; r++)
				issue_req(1'b1, make_addr(a, r, '0), rand_data());
			for (int b = 0; b < NUM_APPS; b++)
				for (int r = 0; r < REGS_PER_APP; r++)
					issue_req(1'b0, make_addr(b, r, '0), '0);
		end
		end_test();

		// Counter sees storage writes only
		start_test("write_counter");
		for (int i = 0; i < 5; i++)
			issue_req(1'b1, make_addr(2, i, '0), rand_data());
		for (int i = 0; i < 3; i++)
			issue_req(1'b1, make_addr(2, CNT_IDX, '0), rand_data());
		issue_req(1'b0, make_addr(2, CNT_IDX, '0), '0);
		end_test();

		// Random mix every cycle
		start_test("back_to_back");
		for (int i = 0; i < 200; i++) begin
			app = {$random(seed)} % NUM_APPS;
			idx = {$random(seed)} % REGS_PER_APP;
			data = rand_data();
			issue_req(data[0], make_addr(app, idx, '0), data);
		end
		end_test();

		// Ignored bits scrambled on both write and read
		start_test("aliasing");
		for (int i = 0; i < 8; i++) begin
			app = {$random(seed)} % NUM_APPS;
			idx = {$random(seed)} % CNT_IDX;
			issue_req(1'b1, make_addr(app, idx, $random(seed)), rand_data());
			issue_req(1'b0, make_addr(app, idx, $random(seed)), '0);
			issue_req(1'b0, make_addr(app, idx, '0), '0);
		end
		end_test();

		// Single read on an idle fabric
		start_test("latency");
		lat_exp = 2 * HOST_STAGES + 2 * APP_STAGES + 3;
		issue_req(1'b0, make_addr(1, 0, '0), '0);
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < TIMEOUT) begin
			@(posedge clk);
			req_valid <= 1'b0;
			cycles++;
			@(negedge clk);
			if (resp_valid === 1'b1)
				seen = 1'b1;
		end
		if (!seen) begin
			stop_on_stall("read response never arrived");
		end else begin
			check_count++;
			if (cycles != lat_exp) begin
				err_count++;
				$display("MISMATCH %s expected %0d actual %0d", test_name, lat_exp, cycles);
			end
			end_test();

			$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
			if (err_count == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

//--- build.f
design/aos_pkg.sv
design/rst_pipe.sv
design/softreg_pipe.sv
design/softreg_route_tree.sv
design/app_regfile.sv
design/aos_top.sv
dv/aos_tb.sv
